/* Bender.yml */
package:
  name: rv32_core

sources:
  - src/rv_isa_pkg.sv
  - src/core_pkg.sv
  - src/pipe_if.sv
  - src/fetch_stage.sv
  - src/reg_file.sv
  - src/decode_stage.sv
  - src/execute_stage.sv
  - src/csr_file.sv
  - src/rv32_core.sv
  - target: test
    files:
      - verif/tb_core.sv

/* src/core_pkg.sv */
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  reg_idx_t;

    // Operations of the execute ALU.
    // Branch compares return their outcome in bit 0.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B,
        ALU_BR_EQ,
        ALU_BR_NE,
        ALU_BR_LT,
        ALU_BR_GE
    } alu_op_e;

    // Reset vector.
    localparam pc_t ENTRY_PC = 32'h0000_0000;
    // External interrupt lines.
    localparam int  NUM_IRQ  = 16;

endpackage

/* src/csr_file.sv */
module csr_file (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [core_pkg::NUM_IRQ-1:0] irq,
    csr_if.file                          csr
);
    import core_pkg::*;
    import rv_isa_pkg::*;

    logic               mstatus_mie;
    logic               mstatus_mpie;
    // Bit i enables irq[i].
    logic [NUM_IRQ-1:0] mie;
    logic [31:2]        mtvec;
    word_t              mscratch;
    pc_t                mepc;
    logic               mcause_int;
    logic [4:0]         mcause_code;

    logic [NUM_IRQ-1:0] pending;
    logic [3:0]         irq_idx;
    logic               irq_take;
    word_t              wr_val;

    assign pending = irq & mie;

    // Lowest-numbered pending line wins.
    always_comb begin
        irq_idx = '0;
        for (int i = NUM_IRQ - 1; i >= 0; i--) begin
            if (pending[i]) begin
                irq_idx = 4'(i);
            end
        end
    end

    // Interrupt replaces a live instruction in execute.
    assign irq_take      = mstatus_mie && (|pending) && csr.insn_valid;
    assign csr.trap_take = csr.trap_req || irq_take;
    assign csr.trap_vec  = {mtvec, 2'b00};

    always_comb begin
        case (csr.csr_addr)
            CSR_MSTATUS:  csr.csr_rdata = {24'd0, mstatus_mpie, 3'd0, mstatus_mie, 3'd0};
            CSR_MIE:      csr.csr_rdata = {{(32 - NUM_IRQ){1'b0}}, mie};
            CSR_MTVEC:    csr.csr_rdata = {mtvec, 2'b00};
            CSR_MSCRATCH: csr.csr_rdata = mscratch;
            CSR_MEPC:     csr.csr_rdata = mepc;
            CSR_MCAUSE:   csr.csr_rdata = {mcause_int, 26'd0, mcause_code};
            default:      csr.csr_rdata = '0;
        endcase
    end

    // CSRRS sets bits, CSRRW replaces.
    assign wr_val = csr.csr_set ? (csr.csr_rdata | csr.csr_wdata) : csr.csr_wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie          <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause_int   <= 1'b0;
            mcause_code  <= '0;
        end else if (csr.trap_take) begin
            // Trap entry.
            mepc         <= csr.trap_pc;
            mcause_int   <= !csr.trap_req;
            mcause_code  <= csr.trap_req ? CAUSE_ILLEGAL : IRQ_BASE + {1'b0, irq_idx};
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
        end else if (csr.csr_we) begin
            case (csr.csr_addr)
                CSR_MSTATUS: begin
                    mstatus_mie  <= wr_val[3];
                    mstatus_mpie <= wr_val[7];
                end
                CSR_MIE:      mie      <= wr_val[NUM_IRQ-1:0];
                CSR_MTVEC:    mtvec    <= wr_val[31:2];
                CSR_MSCRATCH: mscratch <= wr_val;
                CSR_MEPC:     mepc     <= wr_val;
                CSR_MCAUSE: begin
                    mcause_int  <= wr_val[31];
                    mcause_code <= wr_val[4:0];
                end
                default: ;
            endcase
        end
    end

    // An interrupt needs MIE and leaves it clear afterwards.
    assert property (@(posedge clk) disable iff (!rst_n)
        csr.trap_take && !csr.trap_req |-> mstatus_mie ##1 !mstatus_mie);

endmodule

/* src/decode_stage.sv */
module decode_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               fd_valid,
    input  core_pkg::pc_t      fd_pc,
    input  core_pkg::word_t    fd_insn,
    input  logic               flush,
    input  core_pkg::word_t    rdata1,
    input  core_pkg::word_t    rdata2,
    input  logic               wb_en,
    input  core_pkg::reg_idx_t wb_rd,
    input  core_pkg::word_t    wb_data,
    output core_pkg::reg_idx_t rs1,
    output core_pkg::reg_idx_t rs2,
    output logic               predict_jump,
    output core_pkg::pc_t      predict_pc,
    id_ex_if.producer          id_ex
);
    import core_pkg::*;
    import rv_isa_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    // Sign-extended immediates.
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;
    word_t      imm_b;
    // Operands after forwarding.
    word_t      op1;
    word_t      op2;
    pc_t        br_target;
    pc_t        fall_pc;
    // funct3 lookups.
    alu_op_e    f3_op;
    logic       f3_ok;
    alu_op_e    br_op;
    logic       br_ok;
    // Decoded fields.
    reg_idx_t   d_rd;
    word_t      d_rhs;
    alu_op_e    d_alu_op;
    logic       d_branch;
    logic       d_store;
    logic       d_csr;
    logic       d_illegal;

    assign rs1    = fd_insn[19:15];
    assign rs2    = fd_insn[24:20];
    assign rd     = fd_insn[11:7];
    assign funct3 = fd_insn[14:12];
    assign funct7 = fd_insn[31:25];

    assign imm_i = {{20{fd_insn[31]}}, fd_insn[31:20]};
    assign imm_s = {{20{fd_insn[31]}}, fd_insn[31:25], fd_insn[11:7]};
    assign imm_u = {fd_insn[31:12], 12'd0};
    assign imm_b = {{19{fd_insn[31]}}, fd_insn[31], fd_insn[7], fd_insn[30:25],
                    fd_insn[11:8], 1'b0};

    // Result in execute this cycle bypasses the register file.
    assign op1 = (wb_en && wb_rd != 5'd0 && wb_rd == rs1) ? wb_data : rdata1;
    assign op2 = (wb_en && wb_rd != 5'd0 && wb_rd == rs2) ? wb_data : rdata2;

    assign br_target = fd_pc + imm_b;
    assign fall_pc   = fd_pc + 32'd4;

    // Backward branch, i.e. negative offset, is predicted taken.
    assign predict_jump = fd_valid && d_branch && fd_insn[31];
    assign predict_pc   = br_target;

    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            F3_ADD:  f3_op = ALU_ADD;
            F3_SLT:  f3_op = ALU_SLT;
            F3_XOR:  f3_op = ALU_XOR;
            F3_OR:   f3_op = ALU_OR;
            F3_AND:  f3_op = ALU_AND;
            default: begin
                f3_op = ALU_ADD;
                f3_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        br_ok = 1'b1;
        case (funct3)
            F3_BEQ:  br_op = ALU_BR_EQ;
            F3_BNE:  br_op = ALU_BR_NE;
            F3_BLT:  br_op = ALU_BR_LT;
            F3_BGE:  br_op = ALU_BR_GE;
            default: begin
                br_op = ALU_BR_EQ;
                br_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        d_rd      = rd;
        d_rhs     = op2;
        d_alu_op  = f3_op;
        d_branch  = 1'b0;
        d_store   = 1'b0;
        d_csr     = 1'b0;
        d_illegal = 1'b0;
        case (opcode_e'(fd_insn[6:0]))
            OPC_LUI: begin
                d_rhs    = imm_u;
                d_alu_op = ALU_PASS_B;
            end
            OPC_OP_IMM: begin
                d_rhs     = imm_i;
                d_illegal = !f3_ok;
            end
            OPC_OP: begin
                if (funct7 == F7_SUB && funct3 == F3_ADD) begin
                    d_alu_op = ALU_SUB;
                end else if (funct7 != 7'd0 || !f3_ok) begin
                    d_illegal = 1'b1;
                end
            end
            OPC_BRANCH: begin
                d_rd      = '0;
                d_alu_op  = br_op;
                d_branch  = br_ok;
                d_illegal = !br_ok;
            end
            OPC_STORE: begin
                // Address is rs1 plus offset through the adder.
                d_rd      = '0;
                d_rhs     = imm_s;
                d_alu_op  = ALU_ADD;
                d_store   = (funct3 == F3_SW);
                d_illegal = (funct3 != F3_SW);
            end
            OPC_SYSTEM: begin
                d_csr     = (funct3 == F3_CSRRW || funct3 == F3_CSRRS);
                d_illegal = !d_csr;
            end
            default: d_illegal = 1'b1;
        endcase
        // Trapping words write nothing back.
        if (d_illegal) begin
            d_rd = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid <= fd_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.pc            <= fd_pc;
        id_ex.rd            <= d_rd;
        id_ex.lhs           <= op1;
        id_ex.rhs           <= d_rhs;
        id_ex.store_data    <= op2;
        id_ex.alu_op        <= d_alu_op;
        id_ex.is_branch     <= d_branch;
        id_ex.predict_taken <= fd_insn[31];
        // Keep the other path for a misprediction.
        id_ex.branch_alt_pc <= fd_insn[31] ? fall_pc : br_target;
        id_ex.is_store      <= d_store;
        id_ex.is_csr        <= d_csr;
        id_ex.csr_addr      <= fd_insn[31:20];
        id_ex.csr_set       <= (funct3 == F3_CSRRS);
        id_ex.illegal       <= d_illegal;
    end

endmodule

/* src/execute_stage.sv */
module execute_stage (
    input  logic               clk,
    input  logic               rst_n,
    id_ex_if.consumer          id_ex,
    csr_if.exec                csr,
    output logic               redirect,
    output core_pkg::pc_t      redirect_pc,
    output logic               wb_en,
    output core_pkg::reg_idx_t wb_rd,
    output core_pkg::word_t    wb_data,
    output logic               mem_we,
    output core_pkg::pc_t      mem_addr,
    output core_pkg::word_t    mem_wdata
);
    import core_pkg::*;

    word_t alu_res;
    logic  taken;
    // Instruction completes unless a trap replaces it.
    logic  retire;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_res = id_ex.lhs + id_ex.rhs;
            ALU_SUB:    alu_res = id_ex.lhs - id_ex.rhs;
            ALU_AND:    alu_res = id_ex.lhs & id_ex.rhs;
            ALU_OR:     alu_res = id_ex.lhs | id_ex.rhs;
            ALU_XOR:    alu_res = id_ex.lhs ^ id_ex.rhs;
            ALU_SLT:    alu_res = {31'd0, $signed(id_ex.lhs) < $signed(id_ex.rhs)};
            ALU_PASS_B: alu_res = id_ex.rhs;
            ALU_BR_EQ:  alu_res = {31'd0, id_ex.lhs == id_ex.rhs};
            ALU_BR_NE:  alu_res = {31'd0, id_ex.lhs != id_ex.rhs};
            ALU_BR_LT:  alu_res = {31'd0, $signed(id_ex.lhs) < $signed(id_ex.rhs)};
            ALU_BR_GE:  alu_res = {31'd0, $signed(id_ex.lhs) >= $signed(id_ex.rhs)};
            default:    alu_res = '0;
        endcase
    end

    assign taken  = alu_res[0];
    assign retire = id_ex.valid && !csr.trap_take;

    // CSR file sees the access; it drops the write itself on a trap.
    assign csr.csr_addr   = id_ex.csr_addr;
    assign csr.csr_wdata  = id_ex.lhs;
    assign csr.csr_we     = id_ex.valid && id_ex.is_csr;
    assign csr.csr_set    = id_ex.csr_set;
    assign csr.insn_valid = id_ex.valid;
    assign csr.trap_req   = id_ex.valid && id_ex.illegal;
    assign csr.trap_pc    = id_ex.pc;

    // Trap vector wins over a branch correction.
    assign redirect    = csr.trap_take ||
                         (id_ex.valid && id_ex.is_branch && taken != id_ex.predict_taken);
    assign redirect_pc = csr.trap_take ? csr.trap_vec : id_ex.branch_alt_pc;

    assign wb_en   = retire && id_ex.rd != 5'd0;
    assign wb_rd   = id_ex.rd;
    assign wb_data = id_ex.is_csr ? csr.csr_rdata : alu_res;

    // Word store, done in this cycle.
    assign mem_we    = retire && id_ex.is_store;
    assign mem_addr  = alu_res;
    assign mem_wdata = id_ex.store_data;

    // Decode never gives a store a destination register.
    assert property (@(posedge clk) disable iff (!rst_n) !(mem_we && wb_en));

endmodule

/* src/fetch_stage.sv */
module fetch_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            redirect,
    input  core_pkg::pc_t   redirect_pc,
    input  logic            predict_jump,
    input  core_pkg::pc_t   predict_pc,
    input  core_pkg::word_t prog_data,
    output core_pkg::pc_t   prog_addr,
    output logic            fd_valid,
    output core_pkg::pc_t   fd_pc,
    output core_pkg::word_t fd_insn
);
    import core_pkg::*;

    pc_t pc;
    pc_t next_pc;

    // Program bus is read in the same cycle.
    assign prog_addr = pc;

    // Execute redirect beats the decode prediction.
    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (predict_jump) begin
            next_pc = predict_pc;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= ENTRY_PC;
            fd_valid <= 1'b0;
        end else begin
            pc       <= next_pc;
            // Word fetched now lies on a dead path.
            fd_valid <= !(redirect || predict_jump);
        end
    end

    always_ff @(posedge clk) begin
        fd_pc   <= pc;
        fd_insn <= prog_data;
    end

    // Branch targets, trap vectors and the entry point stay word-aligned.
    assert property (@(posedge clk) disable iff (!rst_n) prog_addr[1:0] == 2'b00);

endmodule

/* src/pipe_if.sv */
interface id_ex_if;
    import core_pkg::*;

    logic        valid;
    pc_t         pc;
    // Zero when nothing is written back.
    reg_idx_t    rd;
    word_t       lhs;
    word_t       rhs;
    word_t       store_data;
    alu_op_e     alu_op;
    logic        is_branch;
    logic        predict_taken;
    // Path the predictor did not follow.
    pc_t         branch_alt_pc;
    logic        is_store;
    logic        is_csr;
    logic [11:0] csr_addr;
    // CSRRS when set, CSRRW otherwise.
    logic        csr_set;
    logic        illegal;

    modport producer (
        output valid, pc, rd, lhs, rhs, store_data, alu_op, is_branch, predict_taken,
        output branch_alt_pc, is_store, is_csr, csr_addr, csr_set, illegal
    );
    modport consumer (
        input valid, pc, rd, lhs, rhs, store_data, alu_op, is_branch, predict_taken,
        input branch_alt_pc, is_store, is_csr, csr_addr, csr_set, illegal
    );
endinterface

interface csr_if;
    import core_pkg::*;

    logic [11:0] csr_addr;
    word_t       csr_wdata;
    logic        csr_we;
    logic        csr_set;
    // Execute holds a live instruction.
    logic        insn_valid;
    logic        trap_req;
    pc_t         trap_pc;
    word_t       csr_rdata;
    logic        trap_take;
    pc_t         trap_vec;

    modport exec (
        output csr_addr, csr_wdata, csr_we, csr_set, insn_valid, trap_req, trap_pc,
        input  csr_rdata, trap_take, trap_vec
    );
    modport file (
        input  csr_addr, csr_wdata, csr_we, csr_set, insn_valid, trap_req, trap_pc,
        output csr_rdata, trap_take, trap_vec
    );
endinterface

/* src/reg_file.sv */
module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::reg_idx_t rs1,
    input  core_pkg::reg_idx_t rs2,
    input  logic               we,
    input  core_pkg::reg_idx_t rd,
    input  core_pkg::word_t    wdata,
    output core_pkg::word_t    rdata1,
    output core_pkg::word_t    rdata2
);
    import core_pkg::*;

    // x0 has no storage.
    word_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // Writes show up next cycle; decode forwards the current one.
    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* src/rv32_core.sv */
module rv32_core (
    input  logic                         clk,
    input  logic                         rst_n,
    output core_pkg::pc_t                prog_addr,
    input  core_pkg::word_t              prog_data,
    output logic                         mem_we,
    output core_pkg::pc_t                mem_addr,
    output core_pkg::word_t              mem_wdata,
    input  logic [core_pkg::NUM_IRQ-1:0] irq
);
    import core_pkg::*;

    // Redirect and prediction paths.
    logic     redirect;
    pc_t      redirect_pc;
    logic     predict_jump;
    pc_t      predict_pc;
    // Fetch/decode register.
    logic     fd_valid;
    pc_t      fd_pc;
    word_t    fd_insn;
    // Register file access.
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rdata1;
    word_t    rdata2;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;

    id_ex_if id_ex ();
    csr_if   csr ();

    fetch_stage i_fetch (
        .clk(clk), .rst_n(rst_n),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .predict_jump(predict_jump), .predict_pc(predict_pc),
        .prog_data(prog_data), .prog_addr(prog_addr),
        .fd_valid(fd_valid), .fd_pc(fd_pc), .fd_insn(fd_insn)
    );

    reg_file i_regs (
        .clk(clk), .rst_n(rst_n),
        .rs1(rs1), .rs2(rs2),
        .we(wb_en), .rd(wb_rd), .wdata(wb_data),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    // Execute redirect flushes the decode/execute register.
    decode_stage i_decode (
        .clk(clk), .rst_n(rst_n),
        .fd_valid(fd_valid), .fd_pc(fd_pc), .fd_insn(fd_insn), .flush(redirect),
        .rdata1(rdata1), .rdata2(rdata2),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .rs1(rs1), .rs2(rs2),
        .predict_jump(predict_jump), .predict_pc(predict_pc),
        .id_ex(id_ex)
    );

    execute_stage i_execute (
        .clk(clk), .rst_n(rst_n),
        .id_ex(id_ex), .csr(csr),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    csr_file i_csr (
        .clk(clk), .rst_n(rst_n),
        .irq(irq),
        .csr(csr)
    );

endmodule

/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

    // Major opcodes of the supported RV32I subset.
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011,
        OPC_STORE  = 7'b0100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // ALU function, shared by OP and OP-IMM.
    typedef enum logic [2:0] {
        F3_ADD = 3'b000,
        F3_SLT = 3'b010,
        F3_XOR = 3'b100,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_alu_e;

    // Branch conditions.
    typedef enum logic [2:0] {
        F3_BEQ = 3'b000,
        F3_BNE = 3'b001,
        F3_BLT = 3'b100,
        F3_BGE = 3'b101
    } funct3_br_e;

    // Zicsr and store selectors.
    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;
    localparam logic [2:0] F3_SW    = 3'b010;

    // funct7 that turns ADD into SUB.
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // Implemented machine CSRs.
    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342
    } csr_addr_e;

    // Trap causes.
    localparam logic [4:0] CAUSE_ILLEGAL = 5'd2;
    localparam logic [4:0] IRQ_BASE      = 5'd16;

endpackage

/* tb.f */
src/rv_isa_pkg.sv
src/core_pkg.sv
src/pipe_if.sv
src/fetch_stage.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/csr_file.sv
src/rv32_core.sv
verif/tb_core.sv

/* verif/tb_core.sv */
module tb_core;
    import core_pkg::*;

    // Six tests, each far shorter than 200 cycles.
    localparam int    CYCLE_LIMIT = 6 * 200;
    // addi x0, x0, 0.
    localparam word_t NOP         = 32'h0000_0013;

    logic               clk;
    logic               rst_n;
    pc_t                prog_addr;
    word_t              prog_data;
    logic               mem_we;
    pc_t                mem_addr;
    word_t              mem_wdata;
    logic [NUM_IRQ-1:0] irq;

    // Program ROM, 64 words from address 0.
    word_t  rom [0:63];
    int     wr_ptr;
    // Expected stores in program order.
    pc_t    exp_addr [0:31];
    word_t  exp_data [0:31];
    int     exp_count;
    int     store_idx;
    pc_t    next_addr;
    word_t  next_data;
    logic   at_entry;

    int     errors;
    int     errors_at_start;
    int     tests_run;
    int     tests_failed;
    int     cycles;
    integer seed;
    int     delay;

    rv32_core i_dut (
        .clk(clk), .rst_n(rst_n),
        .prog_addr(prog_addr), .prog_data(prog_data),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .irq(irq)
    );

    // Combinational program bus, NOP outside the ROM.
    assign prog_data = (prog_addr[31:8] == 24'd0) ? rom[prog_addr[7:2]] : NOP;
    assign next_addr = exp_addr[store_idx[4:0]];
    assign next_data = exp_data[store_idx[4:0]];
    assign at_entry  = (prog_addr == ENTRY_PC) && !mem_we;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    // Head of the expected list advances on each store.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            store_idx <= 0;
        end else if (mem_we) begin
            store_idx <= store_idx + 1;
        end
    end

    // Fetch sits at the entry point during reset and one cycle after it.
    assert property (@(posedge clk) !rst_n |-> at_entry ##1 at_entry)
    else begin
        errors++;
        $display("error at %0t: prog_addr %h mem_we %b around reset", $time,
                 $sampled(prog_addr), $sampled(mem_we));
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        mem_we && store_idx < exp_count |-> mem_addr == next_addr && mem_wdata == next_data)
    else begin
        errors++;
        $display("error at %0t: store %0d wrote %h to %h, expected %h to %h", $time,
                 $sampled(store_idx), $sampled(mem_wdata), $sampled(mem_addr),
                 $sampled(next_data), $sampled(next_addr));
    end

    // Flushed paths must not store.
    assert property (@(posedge clk) disable iff (!rst_n) mem_we |-> store_idx < exp_count)
    else begin
        errors++;
        $display("error at %0t: extra store of %h to %h after the last expected one",
                 $time, $sampled(mem_wdata), $sampled(mem_addr));
    end

    // RV32I encoders.
    function automatic word_t op_reg(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_idx_t rd, input reg_idx_t rs1,
                                     input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t op_imm(input logic [2:0] f3, input reg_idx_t rd,
                                     input reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t lui(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic word_t store_word(input reg_idx_t rs2, input reg_idx_t rs1,
                                         input logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch(input logic [2:0] f3, input reg_idx_t rs1,
                                     input reg_idx_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // f3 001 is CSRRW, 010 is CSRRS.
    function automatic word_t csr_access(input logic [2:0] f3, input reg_idx_t rd,
                                         input reg_idx_t rs1, input logic [11:0] addr);
        return {addr, rs1, f3, rd, 7'b1110011};
    endfunction

    task automatic clear_program();
        for (int i = 0; i < 64; i++) begin
            rom[i] = NOP;
        end
        wr_ptr    = 0;
        exp_count = 0;
    endtask

    task automatic origin(input pc_t addr);
        wr_ptr = addr[7:2];
    endtask

    task automatic emit(input word_t insn);
        rom[wr_ptr] = insn;
        wr_ptr++;
    endtask

    task automatic expect_store(input pc_t addr, input word_t data);
        exp_addr[exp_count] = addr;
        exp_data[exp_count] = data;
        exp_count++;
    endtask

    task automatic start_test();
        @(posedge clk);
        #5;
        rst_n           = 1'b0;
        irq             = '0;
        errors_at_start = errors;
        clear_program();
    endtask

    task automatic release_reset();
        repeat (3) @(posedge clk);
        #5;
        rst_n = 1'b1;
    endtask

    // Done once all stores are seen and fetch sits at the halt loop.
    task automatic finish_test(input string name, input pc_t halt_pc);
        @(posedge clk);
        #5;
        while (store_idx != exp_count || prog_addr != halt_pc) begin
            @(posedge clk);
            #5;
        end
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
        end
    endtask

    initial begin
        word_t a;
        word_t b;
        word_t c;
        word_t d;
        word_t e;
        word_t f;
        word_t g;
        word_t h;
        word_t v;
        rst_n        = 1'b0;
        irq          = '0;
        seed         = 32'h7f5703f5;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycles       = 0;
        clear_program();

        start_test();
        emit(NOP);
        emit(branch(3'b000, 0, 0, 13'h000));
        release_reset();
        finish_test("reset", 32'h4);

        // Each result feeds the next, with a store in between.
        a = 32'h80001 << 12;
        b = a + 32'hFFFF_FEDD;
        c = b + a;
        d = a - c;
        e = d & b;
        f = e | a;
        g = f ^ d;
        h = ($signed(g) < $signed(c)) ? 32'd1 : 32'd0;
        start_test();
        emit(lui(1, 20'h80001));
        emit(store_word(1, 0, 12'h100));
        // addi -291.
        emit(op_imm(3'b000, 2, 1, 12'hEDD));
        emit(store_word(2, 0, 12'h104));
        emit(op_reg(7'd0, 3'b000, 3, 2, 1));
        emit(store_word(3, 0, 12'h108));
        emit(op_reg(7'b0100000, 3'b000, 4, 1, 3));
        emit(store_word(4, 0, 12'h10c));
        emit(op_reg(7'd0, 3'b111, 5, 4, 2));
        emit(store_word(5, 0, 12'h110));
        emit(op_reg(7'd0, 3'b110, 6, 5, 1));
        emit(store_word(6, 0, 12'h114));
        emit(op_reg(7'd0, 3'b100, 7, 6, 4));
        emit(store_word(7, 0, 12'h118));
        emit(op_reg(7'd0, 3'b010, 8, 7, 3));
        emit(store_word(8, 0, 12'h11c));
        emit(branch(3'b000, 0, 0, 13'h000));
        expect_store(32'h100, a);
        expect_store(32'h104, b);
        expect_store(32'h108, c);
        expect_store(32'h10c, d);
        expect_store(32'h110, e);
        expect_store(32'h114, f);
        expect_store(32'h118, g);
        expect_store(32'h11c, h);
        release_reset();
        finish_test("alu", 32'h40);

        // Five-pass loop, then forward branches with poison stores on skipped paths.
        start_test();
        emit(op_imm(3'b000, 1, 0, 12'h005));
        emit(op_imm(3'b000, 2, 0, 12'h000));
        emit(op_imm(3'b000, 2, 2, 12'h003));
        emit(op_imm(3'b000, 1, 1, 12'hFFF));
        emit(branch(3'b001, 1, 0, 13'h1FF8));
        emit(store_word(2, 0, 12'h200));
        emit(op_imm(3'b000, 3, 0, 12'hFFE));
        emit(op_imm(3'b000, 4, 0, 12'h007));
        emit(branch(3'b000, 3, 4, 13'h008));
        emit(store_word(4, 0, 12'h204));
        emit(branch(3'b001, 3, 4, 13'h008));
        emit(store_word(0, 0, 12'h2f0));
        emit(branch(3'b100, 3, 4, 13'h008));
        emit(store_word(0, 0, 12'h2f0));
        emit(branch(3'b101, 3, 4, 13'h008));
        emit(store_word(3, 0, 12'h208));
        emit(branch(3'b000, 4, 4, 13'h008));
        emit(store_word(0, 0, 12'h2f0));
        emit(branch(3'b101, 4, 3, 13'h008));
        emit(store_word(0, 0, 12'h2f0));
        emit(store_word(1, 0, 12'h20c));
        emit(branch(3'b000, 0, 0, 13'h000));
        expect_store(32'h200, 32'd5 * 32'd3);
        expect_store(32'h204, 32'd7);
        expect_store(32'h208, 32'hFFFF_FFFE);
        expect_store(32'h20c, 32'd0);
        release_reset();
        finish_test("branch", 32'h54);

        // mscratch and mtvec read back their old values.
        v = (32'hABCDE << 12) + 32'h123;
        start_test();
        emit(lui(1, 20'hABCDE));
        emit(op_imm(3'b000, 1, 1, 12'h123));
        emit(csr_access(3'b001, 2, 1, 12'h340));
        emit(store_word(2, 0, 12'h300));
        emit(op_imm(3'b000, 3, 0, 12'h0F0));
        emit(csr_access(3'b010, 4, 3, 12'h340));
        emit(store_word(4, 0, 12'h304));
        emit(csr_access(3'b010, 5, 0, 12'h340));
        emit(store_word(5, 0, 12'h308));
        emit(csr_access(3'b001, 6, 1, 12'h305));
        emit(csr_access(3'b010, 7, 0, 12'h305));
        emit(store_word(6, 0, 12'h30c));
        emit(store_word(7, 0, 12'h310));
        emit(branch(3'b000, 0, 0, 13'h000));
        expect_store(32'h300, 32'd0);
        expect_store(32'h304, v);
        expect_store(32'h308, v | 32'h0F0);
        expect_store(32'h30c, 32'd0);
        expect_store(32'h310, v & ~32'h3);
        release_reset();
        finish_test("csr", 32'h34);

        // All-zero word traps to the handler at 0x40.
        start_test();
        emit(op_imm(3'b000, 1, 0, 12'h040));
        emit(csr_access(3'b001, 0, 1, 12'h305));
        emit(NOP);
        emit(32'h0000_0000);
        emit(store_word(0, 0, 12'h3f0));
        origin(32'h40);
        emit(csr_access(3'b010, 2, 0, 12'h342));
        emit(csr_access(3'b010, 3, 0, 12'h341));
        emit(store_word(2, 0, 12'h400));
        emit(store_word(3, 0, 12'h404));
        emit(branch(3'b000, 0, 0, 13'h000));
        expect_store(32'h400, 32'd2);
        expect_store(32'h404, 32'hc);
        release_reset();
        finish_test("illegal", 32'h50);

        // Spin until irq[3] enters the handler at 0x80.
        start_test();
        emit(op_imm(3'b000, 1, 0, 12'h080));
        emit(csr_access(3'b001, 0, 1, 12'h305));
        emit(op_imm(3'b000, 2, 0, 12'h008));
        emit(csr_access(3'b001, 0, 2, 12'h304));
        emit(csr_access(3'b010, 0, 2, 12'h300));
        emit(op_imm(3'b000, 5, 5, 12'h001));
        emit(branch(3'b000, 0, 0, 13'h1FFC));
        origin(32'h80);
        emit(csr_access(3'b010, 3, 0, 12'h342));
        emit(csr_access(3'b010, 4, 0, 12'h300));
        emit(store_word(3, 0, 12'h500));
        emit(store_word(4, 0, 12'h504));
        emit(branch(3'b000, 0, 0, 13'h000));
        // Interrupt bit plus cause 16 + 3; MPIE is bit 7.
        expect_store(32'h500, 32'h8000_0000 | (32'd16 + 32'd3));
        expect_store(32'h504, 32'd1 << 7);
        release_reset();
        delay = 5 + ($unsigned($random(seed)) % 20);
        repeat (delay) @(posedge clk);
        #5;
        irq[3] = 1'b1;
        finish_test("interrupt", 32'h90);

        $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
